// ==== common/atomic_cfg.svh ====
/* Sizing macros for the atomic memory unit
   Word width, memory depth and reservation granule */

`ifndef ATOMIC_CFG_SVH
`define ATOMIC_CFG_SVH

// Data and address word width
`define AMO_XLEN 32

// Data memory depth in words
`define AMO_MEM_WORDS 256

// Word index width, log2 of the depth
`define AMO_MEM_AW 8

// Low address bits dropped for word indexing and reservation match
`define AMO_GRAIN_BITS 2

`endif

// ==== common/atomic_pkg.sv ====
/* Shared types for the atomic memory unit
   Word type, operation codes and sequencer states */

`default_nettype none

`include "atomic_cfg.svh"

package atomic_pkg;

    // Data and address word
    typedef logic [`AMO_XLEN-1:0] word_t;

    // Operation codes, AMOs kept contiguous at the end
    typedef enum logic [3:0] {
        OP_LOAD    = 4'd0,   // Plain load
        OP_STORE   = 4'd1,   // Plain store
        OP_LR      = 4'd2,   // Load-reserved
        OP_SC      = 4'd3,   // Store-conditional
        OP_AMOSWAP = 4'd4,
        OP_AMOADD  = 4'd5,
        OP_AMOXOR  = 4'd6,
        OP_AMOAND  = 4'd7,
        OP_AMOOR   = 4'd8,
        OP_AMOMIN  = 4'd9,   // Signed
        OP_AMOMAX  = 4'd10,  // Signed
        OP_AMOMINU = 4'd11,  // Unsigned
        OP_AMOMAXU = 4'd12   // Unsigned
    } atomic_op_e;

    // Sequencer states
    typedef enum logic [1:0] {
        ST_IDLE   = 2'd0,    // Waiting for req
        ST_READ   = 2'd1,    // Read data arriving from memory
        ST_MODIFY = 2'd2,    // ALU result written back to memory
        ST_WRITE  = 2'd3     // Result handed to the requester, done high
    } seq_state_e;

endpackage

`default_nettype wire

// ==== atomic/reservation_station.sv ====
/* LR/SC reservation register with word-granular address match
   Invalidation priority and combinational SC verdict */

`timescale 1ns/1ps
`default_nettype none

`include "atomic_cfg.svh"

module reservation_station
    import atomic_pkg::*;
(
    input  wire        clk,
    input  wire        reset,
    input  wire        lr_valid,     // LR accepted this cycle
    input  wire word_t lr_addr,
    input  wire        sc_valid,     // SC accepted this cycle
    input  wire word_t sc_addr,
    output logic       sc_success,   // Same cycle as sc_valid
    input  wire        invalidate,   // Snooped write from another agent
    input  wire word_t inv_addr,
    input  wire        exception,
    input  wire        interrupt
);

    logic  reserved;        // Reservation held
    word_t reserved_addr;   // Granule-aligned reserved address
    word_t lr_granule;
    word_t sc_granule;
    word_t inv_granule;
    logic  sc_match;
    logic  inv_match;

    // Drop the byte offset within the word
    assign lr_granule  = {lr_addr[`AMO_XLEN-1:`AMO_GRAIN_BITS], {`AMO_GRAIN_BITS{1'b0}}};
    assign sc_granule  = {sc_addr[`AMO_XLEN-1:`AMO_GRAIN_BITS], {`AMO_GRAIN_BITS{1'b0}}};
    assign inv_granule = {inv_addr[`AMO_XLEN-1:`AMO_GRAIN_BITS], {`AMO_GRAIN_BITS{1'b0}}};

    assign sc_match  = reserved && (reserved_addr == sc_granule);
    assign inv_match = invalidate && reserved && (reserved_addr == inv_granule);

    // Verdict uses the reservation as it stands this cycle
    assign sc_success = sc_valid && sc_match;

    // Trap first, then snoop, then SC, then LR
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            reserved      <= 1'b0;
            reserved_addr <= '0;
        end else if (exception || interrupt) begin
            reserved <= 1'b0;               // Any trap drops it
        end else if (inv_match) begin
            reserved <= 1'b0;               // Another agent wrote the word
        end else if (sc_valid) begin
            reserved <= 1'b0;               // SC consumes it, pass or fail
        end else if (lr_valid) begin
            reserved      <= 1'b1;
            reserved_addr <= lr_granule;
        end
    end

    // Sequencer accepts one operation per cycle
    a_lr_sc_exclusive: assert property (
        @(posedge clk) disable iff (reset)
        !(lr_valid && sc_valid)
    ) else $error("LR and SC strobes high together");

    // No verdict without a live SC
    a_success_needs_sc: assert property (
        @(posedge clk) disable iff (reset)
        sc_success |-> sc_valid
    ) else $error("sc_success without sc_valid");

endmodule

`default_nettype wire

// ==== atomic/amo_alu.sv ====
/* New-value computation for the AMO read-modify-write operations
   Non-AMO codes pass the operand through as store data */

`timescale 1ns/1ps
`default_nettype none

module amo_alu
    import atomic_pkg::*;
(
    input  wire atomic_op_e op,
    input  wire word_t      old_val,    // Word read from memory
    input  wire word_t      operand,    // rs2 value from the request
    output word_t           new_val     // Word to store
);

    logic lt_signed;
    logic lt_unsigned;

    assign lt_signed   = ($signed(old_val) < $signed(operand));
    assign lt_unsigned = (old_val < operand);

    always_comb begin
        case (op)
            OP_AMOSWAP: new_val = operand;
            OP_AMOADD:  new_val = old_val + operand;    // Wraps
            OP_AMOXOR:  new_val = old_val ^ operand;
            OP_AMOAND:  new_val = old_val & operand;
            OP_AMOOR:   new_val = old_val | operand;
            OP_AMOMIN:  new_val = lt_signed ? old_val : operand;
            OP_AMOMAX:  new_val = lt_signed ? operand : old_val;
            OP_AMOMINU: new_val = lt_unsigned ? old_val : operand;
            OP_AMOMAXU: new_val = lt_unsigned ? operand : old_val;
            // Store and SC data, load paths ignore it
            default:    new_val = operand;
        endcase
    end

endmodule

`default_nettype wire

// ==== atomic/atomic_sequencer.sv ====
/* Operation sequencer for the atomic unit
   Issues read, modify and write steps, reservation strobes, done and rdata */

`timescale 1ns/1ps
`default_nettype none

`include "atomic_cfg.svh"

module atomic_sequencer
    import atomic_pkg::*;
(
    input  wire                    clk,
    input  wire                    reset,
    input  wire                    req,          // One-cycle request strobe
    input  wire atomic_op_e        op,
    input  wire word_t             addr,
    input  wire word_t             wdata,
    output logic                   done,         // One-cycle completion pulse
    output word_t                  rdata,        // Valid with done
    output logic                   busy,
    output logic                   lr_valid,
    output logic                   sc_valid,
    input  wire                    sc_success,
    output logic                   mem_en,
    output logic                   mem_we,
    output logic [`AMO_MEM_AW-1:0] mem_addr,     // Word index
    output word_t                  mem_wdata,
    input  wire word_t             mem_rdata,
    output atomic_op_e             alu_op,
    output word_t                  alu_old,
    output word_t                  alu_operand,
    input  wire word_t             alu_result
);

    seq_state_e             state;
    atomic_op_e             op_q;         // Operation in flight
    logic [`AMO_MEM_AW-1:0] addr_q;       // Word index in flight
    word_t                  operand_q;    // Latched wdata
    word_t                  old_q;        // Word read for an AMO
    word_t                  rdata_q;
    logic                   idle;
    logic                   accept;
    logic                   op_is_amo;
    logic [`AMO_MEM_AW-1:0] req_index;

    assign idle      = (state == ST_IDLE);
    assign accept    = req && idle;       // Req while busy is dropped
    assign req_index = addr[`AMO_GRAIN_BITS +: `AMO_MEM_AW];
    assign op_is_amo = op_q inside {OP_AMOSWAP, OP_AMOADD, OP_AMOXOR, OP_AMOAND,
                                    OP_AMOOR, OP_AMOMIN, OP_AMOMAX, OP_AMOMINU,
                                    OP_AMOMAXU};

    // Reservation strobes in the accept cycle
    assign lr_valid = accept && (op == OP_LR);
    assign sc_valid = accept && (op == OP_SC);

    // Request fields feed the ALU directly in the accept cycle
    assign alu_op      = idle ? op : op_q;
    assign alu_operand = idle ? wdata : operand_q;
    assign alu_old     = old_q;

    // Memory port, every write takes the ALU result
    always_comb begin
        mem_en    = 1'b0;
        mem_we    = 1'b0;
        mem_addr  = addr_q;
        mem_wdata = alu_result;
        case (state)
            ST_IDLE: begin
                mem_addr = req_index;
                if (req) begin
                    mem_en = (op != OP_SC) || sc_success;   // Failed SC leaves memory alone
                    mem_we = (op == OP_STORE) || ((op == OP_SC) && sc_success);
                end
            end
            ST_MODIFY: begin
                mem_en = 1'b1;              // AMO write-back
                mem_we = 1'b1;
            end
            default: begin
                mem_en = 1'b0;              // Read data held by the memory
            end
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state   <= ST_IDLE;
            op_q    <= OP_LOAD;
            rdata_q <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (req) begin
                        op_q <= op;
                        case (op)
                            OP_STORE: begin
                                state   <= ST_WRITE;    // Written at this edge
                                rdata_q <= '0;
                            end
                            OP_SC: begin
                                state   <= ST_WRITE;
                                rdata_q <= {{(`AMO_XLEN-1){1'b0}}, ~sc_success};  // 0 on success
                            end
                            default: state <= ST_READ;  // Load, LR, AMO
                        endcase
                    end
                end
                ST_READ: begin
                    if (op_is_amo) begin
                        state <= ST_MODIFY;
                    end else begin
                        state   <= ST_WRITE;
                        rdata_q <= mem_rdata;           // Load and LR result
                    end
                end
                ST_MODIFY: begin
                    state   <= ST_WRITE;
                    rdata_q <= old_q;                   // AMO returns the old word
                end
                default: state <= ST_IDLE;              // ST_WRITE, done cycle
            endcase
        end
    end

    // Request payload and AMO read data
    always_ff @(posedge clk) begin
        if (accept) begin
            addr_q    <= req_index;
            operand_q <= wdata;
        end
        if (state == ST_READ) begin
            old_q <= mem_rdata;
        end
    end

    assign done  = (state == ST_WRITE);
    assign busy  = !idle;                // Includes the done cycle
    assign rdata = rdata_q;

    // No back-pressure, caller must hold off
    a_no_req_when_busy: assert property (
        @(posedge clk) disable iff (reset)
        busy |-> !req
    ) else $error("req raised while busy in state %s", state.name());

    a_done_single: assert property (
        @(posedge clk) disable iff (reset)
        done |=> !done
    ) else $error("done held longer than one cycle");

endmodule

`default_nettype wire

// ==== design/atomic_dmem.sv ====
/* Single-port word memory for the atomic unit
   Synchronous read, write-first */

`timescale 1ns/1ps
`default_nettype none

`include "atomic_cfg.svh"

module atomic_dmem
    import atomic_pkg::*;
(
    input  wire                   clk,
    input  wire                   en,
    input  wire                   we,
    input  wire [`AMO_MEM_AW-1:0] addr,    // Word index
    input  wire word_t            wdata,
    output word_t                 rdata    // One cycle after an enabled access
);

    word_t mem [`AMO_MEM_WORDS];

    // Start from a cleared array
    initial begin
        for (int i = 0; i < `AMO_MEM_WORDS; i++) begin
            mem[i] = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (en) begin
            if (we) begin
                mem[addr] <= wdata;
                rdata     <= wdata;        // Write-first
            end else begin
                rdata <= mem[addr];
            end
        end
    end

endmodule

`default_nettype wire

// ==== design/atomic_unit.sv ====
/* Top level of the atomic memory unit
   Sequencer, reservation station, AMO ALU and word memory */

`timescale 1ns/1ps
`default_nettype none

`include "atomic_cfg.svh"

module atomic_unit
    import atomic_pkg::*;
(
    input  wire             clk,
    input  wire             reset,
    input  wire             req,
    input  wire atomic_op_e op,
    input  wire word_t      addr,
    input  wire word_t      wdata,
    output logic            done,
    output word_t           rdata,
    output logic            busy,
    input  wire             snoop_valid,   // Write by another agent
    input  wire word_t      snoop_addr,
    input  wire             exception,
    input  wire             interrupt
);

    logic                   lr_valid;
    logic                   sc_valid;
    logic                   sc_success;
    logic                   mem_en;
    logic                   mem_we;
    logic [`AMO_MEM_AW-1:0] mem_addr;
    word_t                  mem_wdata;
    word_t                  mem_rdata;
    atomic_op_e             alu_op;
    word_t                  alu_old;
    word_t                  alu_operand;
    word_t                  alu_result;

    atomic_sequencer i_seq (
        .clk         (clk),
        .reset       (reset),
        .req         (req),
        .op          (op),
        .addr        (addr),
        .wdata       (wdata),
        .done        (done),
        .rdata       (rdata),
        .busy        (busy),
        .lr_valid    (lr_valid),
        .sc_valid    (sc_valid),
        .sc_success  (sc_success),
        .mem_en      (mem_en),
        .mem_we      (mem_we),
        .mem_addr    (mem_addr),
        .mem_wdata   (mem_wdata),
        .mem_rdata   (mem_rdata),
        .alu_op      (alu_op),
        .alu_old     (alu_old),
        .alu_operand (alu_operand),
        .alu_result  (alu_result)
    );

    // LR and SC carry the request address straight through
    reservation_station i_resv (
        .clk        (clk),
        .reset      (reset),
        .lr_valid   (lr_valid),
        .lr_addr    (addr),
        .sc_valid   (sc_valid),
        .sc_addr    (addr),
        .sc_success (sc_success),
        .invalidate (snoop_valid),
        .inv_addr   (snoop_addr),
        .exception  (exception),
        .interrupt  (interrupt)
    );

    amo_alu i_alu (
        .op      (alu_op),
        .old_val (alu_old),
        .operand (alu_operand),
        .new_val (alu_result)
    );

    atomic_dmem i_mem (
        .clk   (clk),
        .en    (mem_en),
        .we    (mem_we),
        .addr  (mem_addr),
        .wdata (mem_wdata),
        .rdata (mem_rdata)
    );

endmodule

`default_nettype wire

// ==== test/atomic_unit_tb.sv ====
/* Table-driven testbench for the atomic memory unit
   Reference memory and reservation model, rdata and done checks, cycle watchdog */

`timescale 1ns/1ps
`default_nettype none

`include "atomic_cfg.svh"

module atomic_unit_tb
    import atomic_pkg::*;
();

    logic       clk;
    logic       reset;
    logic       req;
    atomic_op_e op;
    word_t      addr;
    word_t      wdata;
    logic       done;
    word_t      rdata;
    logic       busy;
    logic       snoop_valid;
    word_t      snoop_addr;
    logic       exception;
    logic       interrupt;

    // Stimulus table, one entry per request
    atomic_op_e tab_op[$];
    word_t      tab_addr[$];
    word_t      tab_wdata[$];
    logic       tab_snoop[$];
    word_t      tab_saddr[$];
    logic       tab_exc[$];
    word_t      tab_exp[$];           // Filled by the model

    word_t  ref_mem [`AMO_MEM_WORDS];  // Memory as the rules leave it
    integer seed = 32'h8884_00ca;
    int     errors = 0;
    int     cycles = 0;
    int     cycle_limit = 0;

    atomic_unit i_dut (
        .clk(clk), .reset(reset), .req(req), .op(op), .addr(addr), .wdata(wdata),
        .done(done), .rdata(rdata), .busy(busy), .snoop_valid(snoop_valid),
        .snoop_addr(snoop_addr), .exception(exception), .interrupt(interrupt)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;        // 100 ns period
    end

    function automatic logic [`AMO_MEM_AW-1:0] word_index(input word_t a);
        return a[`AMO_GRAIN_BITS +: `AMO_MEM_AW];
    endfunction

    // Stored value of an AMO, straight from the ISA definitions
    function automatic word_t amo_value(input atomic_op_e o, input word_t m, input word_t s);
        case (o)
            OP_AMOSWAP: return s;
            OP_AMOADD:  return m + s;
            OP_AMOXOR:  return m ^ s;
            OP_AMOAND:  return m & s;
            OP_AMOOR:   return m | s;
            OP_AMOMIN:  return ($signed(s) < $signed(m)) ? s : m;
            OP_AMOMAX:  return ($signed(s) > $signed(m)) ? s : m;
            OP_AMOMINU: return (s < m) ? s : m;
            default:    return (s > m) ? s : m;      // maxu
        endcase
    endfunction

    task automatic add_row(input atomic_op_e o, input word_t a, input word_t d,
                           input logic sv, input word_t sa, input logic ex);
        tab_op.push_back(o);
        tab_addr.push_back(a);
        tab_wdata.push_back(d);
        tab_snoop.push_back(sv);
        tab_saddr.push_back(sa);
        tab_exc.push_back(ex);
    endtask

    // Walk the table in order, tracking memory and the one reservation
    task automatic predict_all();
        logic                   res_valid;
        word_t                  res_word;
        logic                   sc_ok;
        logic [`AMO_MEM_AW-1:0] idx;
        word_t                  old;
        res_valid = 1'b0;
        res_word  = '0;
        ref_mem   = '{default: '0};
        for (int i = 0; i < tab_op.size(); i++) begin
            idx   = word_index(tab_addr[i]);
            old   = ref_mem[idx];
            sc_ok = res_valid && (res_word == (tab_addr[i] >> `AMO_GRAIN_BITS));
            case (tab_op[i])
                OP_LOAD, OP_LR: tab_exp.push_back(old);
                OP_STORE: begin
                    ref_mem[idx] = tab_wdata[i];
                    tab_exp.push_back('0);
                end
                OP_SC: begin
                    if (sc_ok) ref_mem[idx] = tab_wdata[i];
                    tab_exp.push_back(sc_ok ? 32'd0 : 32'd1);
                end
                default: begin                   // AMO returns the old word
                    ref_mem[idx] = amo_value(tab_op[i], old, tab_wdata[i]);
                    tab_exp.push_back(old);
                end
            endcase
            // Trap, then matching snoop, then SC, then LR
            if (tab_exc[i]) begin
                res_valid = 1'b0;
            end else if (tab_snoop[i] && res_valid &&
                         res_word == (tab_saddr[i] >> `AMO_GRAIN_BITS)) begin
                res_valid = 1'b0;
            end else if (tab_op[i] == OP_SC) begin
                res_valid = 1'b0;
            end else if (tab_op[i] == OP_LR) begin
                res_valid = 1'b1;
                res_word  = tab_addr[i] >> `AMO_GRAIN_BITS;
            end
        end
    endtask

    task automatic build_table();
        word_t r;
        add_row(OP_STORE, 32'h00, 32'h1234_5678, 0, 0, 0);
        add_row(OP_LOAD,  32'h00, 0, 0, 0, 0);
        add_row(OP_STORE, 32'h04, 32'h8000_0005, 0, 0, 0);   // Negative when signed
        add_row(OP_AMOMIN, 32'h04, 32'h0000_0003, 0, 0, 0);
        add_row(OP_LOAD,  32'h04, 0, 0, 0, 0);
        add_row(OP_AMOMAX, 32'h04, 32'h7fff_0000, 0, 0, 0);
        add_row(OP_LOAD,  32'h04, 0, 0, 0, 0);
        add_row(OP_STORE, 32'h08, 32'hffff_fff0, 0, 0, 0);
        add_row(OP_AMOMINU, 32'h08, 32'h0000_0010, 0, 0, 0);
        add_row(OP_AMOMAXU, 32'h08, 32'h9000_0000, 0, 0, 0);
        add_row(OP_LOAD,  32'h08, 0, 0, 0, 0);
        add_row(OP_AMOSWAP, 32'h00, 32'hdead_beef, 0, 0, 0);
        add_row(OP_AMOAND, 32'h00, 32'h0fff_0ff0, 0, 0, 0);
        add_row(OP_AMOOR, 32'h00, 32'h1000_0001, 0, 0, 0);
        add_row(OP_LOAD,  32'h00, 0, 0, 0, 0);
        for (int k = 0; k < 6; k++) begin                  // Random add/xor operands
            r = $random(seed);
            add_row((k % 2 == 0) ? OP_AMOADD : OP_AMOXOR, (k < 3) ? 32'h0c : 32'h10, r, 0, 0, 0);
        end
        add_row(OP_LR,    32'h20, 0, 0, 0, 0);               // LR/SC pair, other byte offset
        add_row(OP_SC,    32'h22, 32'ha5a5_0001, 0, 0, 0);
        add_row(OP_SC,    32'h20, 32'h0000_ffff, 0, 0, 0);   // No reservation left
        add_row(OP_STORE, 32'h24, 32'h11, 0, 0, 0);
        add_row(OP_LR,    32'h24, 0, 0, 0, 0);
        add_row(OP_SC,    32'h28, 32'h22, 0, 0, 0);          // Wrong word
        add_row(OP_LR,    32'h30, 0, 0, 0, 0);
        add_row(OP_LOAD,  32'h00, 0, 1, 32'h31, 0);          // Snoop hits reserved word
        add_row(OP_SC,    32'h30, 32'h55, 0, 0, 0);
        add_row(OP_LR,    32'h30, 0, 0, 0, 0);
        add_row(OP_LOAD,  32'h00, 0, 1, 32'h34, 0);          // Snoop elsewhere
        add_row(OP_SC,    32'h30, 32'h77, 0, 0, 0);
        add_row(OP_LR,    32'h38, 0, 0, 0, 0);
        add_row(OP_LOAD,  32'h00, 0, 0, 0, 1);               // Trap drops reservation
        add_row(OP_SC,    32'h38, 32'h66, 0, 0, 0);
        add_row(OP_LR,    32'h38, 0, 0, 0, 0);
        add_row(OP_SC,    32'h38, 32'h99, 0, 0, 0);
        for (int w = 0; w < 16; w++) begin                  // Final read-back
            add_row(OP_LOAD, word_t'(w * 4), 0, 0, 0, 0);
        end
    endtask

    // One request, then wait for done and check the pulse
    task automatic run_row(input int i);
        int waited;
        req         = 1'b1;
        op          = tab_op[i];
        addr        = tab_addr[i];
        wdata       = tab_wdata[i];
        snoop_valid = tab_snoop[i];
        snoop_addr  = tab_saddr[i];
        exception   = tab_exc[i];
        @(negedge clk);
        req         = 1'b0;
        snoop_valid = 1'b0;
        exception   = 1'b0;
        waited = 1;
        while (!done && waited < 5) begin
            @(negedge clk);
            waited++;
        end
        if (!done) begin
            errors++;
            $display("Row %0d (%s): no done within 5 cycles", i, tab_op[i].name());
        end else begin
            if (rdata !== tab_exp[i]) begin
                errors++;
                $display("** Error rdata exp=%h got=%h (row %0d, %s)",
                         tab_exp[i], rdata, i, tab_op[i].name());
            end
            if (busy !== 1'b1) begin                        // Still busy in the done cycle
                errors++;
                $display("** Error busy exp=%h got=%h (row %0d)", 1'b1, busy, i);
            end
            @(negedge clk);
            if (done !== 1'b0) begin
                errors++;
                $display("** Error done exp=%h got=%h (row %0d)", 1'b0, done, i);
            end
            if (busy !== 1'b0) begin
                errors++;
                $display("** Error busy exp=%h got=%h (row %0d)", 1'b0, busy, i);
            end
        end
    endtask

    initial begin : watchdog
        wait (cycle_limit > 0);
        while (cycles < cycle_limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("Run stopped after %0d cycles without finishing", cycles);
        $display("Test failed");
        $finish;
    end

    initial begin
        reset       = 1'b1;
        req         = 1'b0;
        op          = OP_LOAD;
        addr        = '0;
        wdata       = '0;
        snoop_valid = 1'b0;
        snoop_addr  = '0;
        exception   = 1'b0;
        interrupt   = 1'b0;
        build_table();
        predict_all();
        cycle_limit = tab_op.size() * 8 + 50;
        repeat (2) @(negedge clk);
        reset = 1'b0;
        @(negedge clk);
        for (int i = 0; i < tab_op.size(); i++) begin
            run_row(i);
        end
        $display("Checks done with %0d errors", errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== atomic_unit.f ====
+incdir+common
common/atomic_pkg.sv
atomic/reservation_station.sv
atomic/amo_alu.sv
atomic/atomic_sequencer.sv
design/atomic_dmem.sv
design/atomic_unit.sv
test/atomic_unit_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the atomic unit testbench with Verilator, run it, grade from the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert -f atomic_unit.f --top-module atomic_unit_tb \
    -o atomic_unit_sim > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/atomic_unit_sim > sim.log 2>&1
cat sim.log
grep -q "^Test completed successfully$" sim.log && echo "PASS" && exit 0 || { echo "FAIL"; exit 1; }
